// File: Bender.yml
package:
  name: othello_board

sources:
  - files:
      - logic/othello_pkg.sv
      - logic/uart_rx.sv
      - logic/uart_tx.sv
      - logic/cmd_decode.sv
      - logic/move_scan.sv
      - logic/seg7_bank.sv
      - logic/othello_board_top.sv
  - target: simulation
    files:
      - dv/othello_board_tb.sv

// File: dv/othello_board_tb.sv
`timescale 1ns/1ps

module othello_board_tb;
	import othello_pkg::*;

	localparam int MAX_T = 40; // Test slots for file and random tests
	localparam int MAX_B = 24; // Command bytes per test
	localparam int N_RAND = 6;

	logic clk;
	logic rst_n;
	logic uart_rxd;
	logic uart_txd;
	logic [6:0] hex0, hex1, hex2, hex3, hex4, hex5, hex6, hex7;

	string tname [MAX_T];
	logic [7:0] cmd_bytes [MAX_T][MAX_B]; // Host to DUT
	int n_send [MAX_T];
	logic [7:0] exp_bytes [MAX_T][4]; // Reply bytes in arrival order
	int n_exp [MAX_T];
	logic [31:0] exp_disp [MAX_T];
	bit chk_disp [MAX_T];
	int n_tests = 0;
	int pass_cnt = 0;
	int fail_cnt = 0;
	integer seed = 32'h1c0a;
	longint limit = 64'd1_000_000; // Replaced once the tests are known
	longint cycles = 0;
	logic [31:0] got_reply; // Reply bytes packed with the first byte highest
	bit framing_err;

	othello_board_top UUT (.clk50(clk), .rst_n(rst_n), .uart_rxd(uart_rxd),
		.uart_txd(uart_txd), .hex0(hex0), .hex1(hex1), .hex2(hex2), .hex3(hex3),
		.hex4(hex4), .hex5(hex5), .hex6(hex6), .hex7(hex7));

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk; // 4 ns period
	end

	always @(posedge clk) begin
		cycles = cycles + 1;
		if (cycles > limit) begin
			$display("Timeout: the DUT did not finish within %0d cycles", limit);
			$display("SIMULATION FAILED");
			$finish;
		end
	end

	// Active-low DE2 segments with bit 0 as segment a
	function automatic logic [3:0] seg_value(input logic [6:0] seg);
		case (seg)
			7'b1000000: return 4'h0;
			7'b1111001: return 4'h1;
			7'b0100100: return 4'h2;
			7'b0110000: return 4'h3;
			7'b0011001: return 4'h4;
			7'b0010010: return 4'h5;
			7'b0000010: return 4'h6;
			7'b1111000: return 4'h7;
			7'b0000000: return 4'h8;
			7'b0011000: return 4'h9;
			7'b0001000: return 4'ha;
			7'b0000011: return 4'hb;
			7'b1000110: return 4'hc;
			7'b0100001: return 4'hd;
			7'b0000110: return 4'he;
			7'b0001110: return 4'hf;
			default: return 4'bxxxx; // Not a hex glyph
		endcase
	endfunction

	function automatic logic [31:0] read_display();
		return {seg_value(hex7), seg_value(hex6), seg_value(hex5), seg_value(hex4),
			seg_value(hex3), seg_value(hex2), seg_value(hex1), seg_value(hex0)};
	endfunction

	// Neighbour rule by row and column giving {square byte, count byte}
	function automatic logic [15:0] model_reply(input logic [63:0] own, input logic [63:0] opp);
		int count;
		int first;
		int nr;
		int nc;
		bit hit;
		count = 0;
		first = -1;
		for (int sq = 0; sq < 64; sq++) begin
			hit = 1'b0;
			if (!own[sq] && !opp[sq]) begin
				for (int dr = -1; dr <= 1; dr++) begin
					for (int dc = -1; dc <= 1; dc++) begin
						nr = sq / 8 + dr;
						nc = sq % 8 + dc;
						if ((dr != 0 || dc != 0) && nr >= 0 && nr < 8 && nc >= 0 && nc < 8)
							hit = hit | opp[nr * 8 + nc];
					end
				end
			end
			if (hit) begin
				count++;
				if (first < 0)
					first = sq; // First hit of the ascending scan is the lowest
			end
		end
		return {(first < 0) ? 8'hFF : 8'(first), 8'(count)};
	endfunction

	task automatic load_patterns();
		int fd;
		int rc;
		int v;
		string tok;
		string rest;
		fd = $fopen("dv/othello_patterns.txt", "r");
		if (fd == 0) begin
			$display("Could not open dv/othello_patterns.txt");
			fail_cnt++;
			return;
		end
		while (!$feof(fd)) begin
			rc = $fscanf(fd, "%s", tok);
			if (rc != 1)
				break;
			if (tok.len() > 0 && tok[0] == 8'h23) begin
				rc = $fgets(rest, fd); // Comment line
				continue;
			end
			tname[n_tests] = tok;
			rc = $fscanf(fd, "%d", v);
			n_send[n_tests] = v;
			for (int i = 0; i < n_send[n_tests]; i++) begin
				rc = $fscanf(fd, "%h", v);
				cmd_bytes[n_tests][i] = v[7:0];
			end
			rc = $fscanf(fd, "%d", v);
			n_exp[n_tests] = v;
			for (int i = 0; i < n_exp[n_tests]; i++) begin
				rc = $fscanf(fd, "%h", v);
				exp_bytes[n_tests][i] = v[7:0];
			end
			rc = $fscanf(fd, "%s", tok);
			chk_disp[n_tests] = (tok != "-"); // Dash skips the display
			if (chk_disp[n_tests])
				rc = $sscanf(tok, "%h", exp_disp[n_tests]);
			n_tests++;
		end
		$fclose(fd);
	endtask

	// Loads both boards then searches back to back
	task automatic add_random_tests();
		logic [63:0] own;
		logic [63:0] opp;
		logic [15:0] rep;
		for (int k = 0; k < N_RAND; k++) begin
			own = {$random(seed), $random(seed)} & {$random(seed), $random(seed)};
			opp = {$random(seed), $random(seed)} & {$random(seed), $random(seed)}
				& {$random(seed), $random(seed)} & ~own; // Sparse and never on own squares
			rep = model_reply(own, opp);
			tname[n_tests] = $sformatf("rand_%0d", k);
			cmd_bytes[n_tests][0] = OP_OWN;
			cmd_bytes[n_tests][9] = OP_OPP;
			for (int i = 0; i < 8; i++) begin
				cmd_bytes[n_tests][1 + i] = own[8*i +: 8]; // LS byte first
				cmd_bytes[n_tests][10 + i] = opp[8*i +: 8];
			end
			cmd_bytes[n_tests][18] = OP_GO;
			n_send[n_tests] = 19;
			exp_bytes[n_tests][0] = rep[15:8];
			exp_bytes[n_tests][1] = rep[7:0];
			n_exp[n_tests] = 2;
			exp_disp[n_tests] = {own[15:0], rep};
			chk_disp[n_tests] = 1'b1;
			n_tests++;
		end
	endtask

	// 8N1 frame starting on a falling edge
	task automatic send_byte(input logic [7:0] b);
		uart_rxd = 1'b0; // Start bit
		repeat (CLKS_PER_BIT) @(negedge clk);
		for (int i = 0; i < 8; i++) begin
			uart_rxd = b[i];
			repeat (CLKS_PER_BIT) @(negedge clk);
		end
		uart_rxd = 1'b1; // Stop bit plus a short idle gap
		repeat (CLKS_PER_BIT + 2) @(negedge clk);
	endtask

	task automatic recv_byte(output logic [7:0] b, output bit bad);
		bad = 1'b0;
		@(negedge clk);
		while (uart_txd !== 1'b0)
			@(negedge clk);
		repeat (CLKS_PER_BIT / 2) @(negedge clk); // Middle of start bit
		if (uart_txd !== 1'b0)
			bad = 1'b1;
		for (int i = 0; i < 8; i++) begin
			repeat (CLKS_PER_BIT) @(negedge clk);
			b[i] = uart_txd;
		end
		repeat (CLKS_PER_BIT) @(negedge clk);
		if (uart_txd !== 1'b1)
			bad = 1'b1; // Stop bit missing
	endtask

	task automatic send_frame(input int t);
		for (int i = 0; i < n_send[t]; i++)
			send_byte(cmd_bytes[t][i]);
	endtask

	task automatic collect_reply(input int t);
		logic [7:0] b;
		bit bad;
		got_reply = '0;
		framing_err = 1'b0;
		for (int i = 0; i < n_exp[t]; i++) begin
			recv_byte(b, bad);
			got_reply = {got_reply[23:0], b};
			framing_err = framing_err | bad;
		end
	endtask

	task automatic check_reset();
		logic [31:0] disp;
		disp = read_display();
		if (disp !== 32'h0) begin
			$display("FAIL reset_state display expected 00000000 actual %h", disp);
			fail_cnt++;
		end else if (uart_txd !== 1'b1) begin
			$display("FAIL reset_state uart_txd expected 1 actual %b", uart_txd);
			fail_cnt++;
		end else begin
			$display("PASS reset_state");
			pass_cnt++;
		end
	endtask

	task automatic run_test(input int t);
		logic [31:0] exp_r;
		logic [31:0] disp;
		bit extra_tx;
		exp_r = '0;
		extra_tx = 1'b0;
		@(negedge clk);
		fork
			send_frame(t);
			collect_reply(t); // Unknown opcode replies before the stop bit ends
		join
		for (int i = 0; i < CLKS_PER_BIT; i++) begin
			@(negedge clk);
			if (uart_txd !== 1'b1)
				extra_tx = 1'b1; // Anything past the last stop bit is a surplus byte
		end
		for (int i = 0; i < n_exp[t]; i++)
			exp_r = {exp_r[23:0], exp_bytes[t][i]};
		disp = read_display();
		if (framing_err) begin
			$display("FAIL %s: a reply byte on uart_txd had a bad start or stop bit", tname[t]);
			fail_cnt++;
		end else if (got_reply !== exp_r) begin
			$display("FAIL %s reply expected %h actual %h", tname[t], exp_r, got_reply);
			fail_cnt++;
		end else if (extra_tx) begin
			$display("FAIL %s: uart_txd sent more than the expected reply bytes", tname[t]);
			fail_cnt++;
		end else if (chk_disp[t] && disp !== exp_disp[t]) begin
			$display("FAIL %s display expected %h actual %h", tname[t], exp_disp[t], disp);
			fail_cnt++;
		end else begin
			$display("PASS %s", tname[t]);
			pass_cnt++;
		end
	endtask

	initial begin
		longint total;
		longint searches;
		rst_n = 1'b0;
		uart_rxd = 1'b1; // Serial idle
		load_patterns();
		add_random_tests();
		total = 0;
		searches = 0;
		for (int t = 0; t < n_tests; t++) begin
			total += n_send[t] + n_exp[t];
			for (int i = 0; i < n_send[t]; i++)
				if (cmd_bytes[t][i] == OP_GO)
					searches++;
		end
		// Doubled frame time plus scans, per-test gaps and reset
		limit = 2 * total * 10 * CLKS_PER_BIT + 64 * searches
			+ (CLKS_PER_BIT + 2) * (n_tests + 1) + 20;
		repeat (5) @(posedge clk);
		@(negedge clk);
		rst_n = 1'b1;
		repeat (4) @(negedge clk);
		check_reset();
		for (int t = 0; t < n_tests; t++)
			run_test(t);
		$display("Tests passed %0d, failed %0d", pass_cnt, fail_cnt);
		if (fail_cnt == 0)
			$display("SIMULATION PASSED");
		else
			$display("SIMULATION FAILED");
		$finish;
	end

endmodule

// File: dv/othello_patterns.txt
# name n_send send_bytes(hex) n_reply reply_bytes(hex) display(hex, - skips the check)
# Opcodes 4F own, 58 opp, 47 search; board bytes go least significant first
unknown_op 1 A5 1 3F 00000000
edge_wrap 19 4F 03 00 00 00 00 00 00 00 58 00 01 00 00 00 00 00 00 47 2 09 03 00030903
corners 19 4F C3 A5 00 00 00 00 00 00 58 00 00 00 00 00 00 00 81 47 2 30 06 A5C33006
no_opp 19 4F 34 12 00 00 00 00 00 00 58 00 00 00 00 00 00 00 00 47 2 FF 00 1234FF00
row_zero 19 4F 00 00 00 00 00 00 00 00 58 FF 00 00 00 00 00 00 00 47 2 08 08 00000808
east_edge 10 58 00 80 00 00 00 00 00 00 47 2 06 05 00000605
west_edge 10 58 00 00 01 00 00 00 00 00 47 2 08 05 00000805
checker 10 58 AA 55 AA 55 AA 55 AA 55 47 2 00 20 00000020
full_opp 10 58 FF FF FF FF FF FF FF FF 47 2 FF 00 0000FF00
load_only 9 4F 00 00 0C 00 00 00 00 00 0 -
mid_board 10 58 00 00 00 08 00 00 00 00 47 2 14 06 00001406
repeat_go 1 47 2 14 06 00001406
unknown_keeps 1 5A 1 3F 00001406

// File: logic/cmd_decode.sv
`timescale 1ns/1ps

module cmd_decode (
	input logic clk50,
	input logic rst_n,
	input logic [7:0] rx_data,
	input logic rx_ready,
	output logic [7:0] tx_data,
	output logic tx_start,
	input logic tx_busy,
	output othello_pkg::board_t own_board,
	output othello_pkg::board_t opp_board,
	output logic scan_start,
	input logic scan_done,
	input othello_pkg::move_result_t result,
	output othello_pkg::display_t display
);
	import othello_pkg::*;

	typedef enum logic [2:0] {
		S_IDLE, // Waiting for an opcode
		S_LOAD, // Collecting 8 board bytes
		S_SCAN, // Search running
		S_SEND, // Next reply byte once the transmitter is free
		S_ACK // Wait for tx_busy to rise
	} dec_state_t;

	dec_state_t state;
	logic load_opp; // Which board S_LOAD fills
	logic [2:0] byte_cnt;
	logic bytes_left; // Second reply byte still queued
	logic [15:0] reply_q; // Upper byte goes out first
	logic known_op;
	logic [7:0] sq_byte;
	logic [7:0] cnt_byte;

	assign known_op = (rx_data == OP_OWN) || (rx_data == OP_OPP) || (rx_data == OP_GO);
	assign sq_byte = result.found ? {2'b00, result.square} : NO_MOVE;
	assign cnt_byte = {1'b0, result.count};

	always_ff @(posedge clk50) begin
		if (!rst_n) begin
			state <= S_IDLE;
			load_opp <= 1'b0;
			byte_cnt <= '0;
			bytes_left <= 1'b0;
			tx_start <= 1'b0;
			scan_start <= 1'b0;
			own_board <= '0;
			opp_board <= '0;
			display <= '0;
		end else begin
			tx_start <= 1'b0;
			scan_start <= 1'b0;
			case (state)
				S_IDLE: begin
					if (rx_ready) begin
						byte_cnt <= '0;
						if (rx_data == OP_OWN || rx_data == OP_OPP) begin
							load_opp <= (rx_data == OP_OPP);
							state <= S_LOAD;
						end else if (rx_data == OP_GO) begin
							scan_start <= 1'b1;
							state <= S_SCAN;
						end else begin
							bytes_left <= 1'b0; // Single '?' reply
							state <= S_SEND;
						end
					end
				end
				S_LOAD: begin
					if (rx_ready) begin
						// LS byte first, ends up in [7:0] after eight shifts
						if (load_opp)
							opp_board <= {rx_data, opp_board[63:8]};
						else
							own_board <= {rx_data, own_board[63:8]};
						byte_cnt <= byte_cnt + 3'd1;
						if (byte_cnt == 3'd7)
							state <= S_IDLE;
					end
				end
				S_SCAN: begin
					if (scan_done) begin
						bytes_left <= 1'b1; // Square, then count
						display <= '{own_low: own_board[15:0], square: sq_byte, count: cnt_byte};
						state <= S_SEND;
					end
				end
				S_SEND: begin
					if (!tx_busy) begin
						tx_start <= 1'b1;
						state <= S_ACK;
					end
				end
				default: begin // S_ACK
					// busy lags tx_start by a cycle, so wait for it before the next byte
					if (tx_busy) begin
						bytes_left <= 1'b0;
						state <= bytes_left ? S_SEND : S_IDLE;
					end
				end
			endcase
		end
	end

	// Reply bytes
	always_ff @(posedge clk50) begin
		if (state == S_IDLE && rx_ready && !known_op)
			reply_q <= {REPLY_UNKNOWN, 8'h00};
		else if (state == S_SCAN && scan_done)
			reply_q <= {sq_byte, cnt_byte};
		else if (state == S_SEND && !tx_busy) begin
			tx_data <= reply_q[15:8];
			reply_q <= {reply_q[7:0], 8'h00};
		end
	end

endmodule

// File: logic/move_scan.sv
`timescale 1ns/1ps

module move_scan (
	input logic clk50,
	input logic rst_n,
	input othello_pkg::board_t own_board,
	input othello_pkg::board_t opp_board,
	input logic scan_start,
	output logic scan_done,
	output othello_pkg::move_result_t result
);
	import othello_pkg::*;

	logic running;
	logic [5:0] sq; // Square under test
	logic [2:0] row;
	logic [2:0] col;
	logic n_ok; // Neighbour row above exists
	logic s_ok;
	logic w_ok;
	logic e_ok;
	logic nbr_hit; // Some in-board neighbour holds an opponent piece
	logic cand;

	assign row = sq[5:3];
	assign col = sq[2:0];
	assign n_ok = (row != 3'd0);
	assign s_ok = (row != 3'd7);
	assign w_ok = (col != 3'd0); // Stops wrap from col 0 to col 7 of the row above
	assign e_ok = (col != 3'd7);

	// Index arithmetic wraps in 6 bits, the edge masks kill those terms
	assign nbr_hit = (n_ok && opp_board[sq - 6'd8])
		|| (s_ok && opp_board[sq + 6'd8])
		|| (w_ok && opp_board[sq - 6'd1])
		|| (e_ok && opp_board[sq + 6'd1])
		|| (n_ok && w_ok && opp_board[sq - 6'd9])
		|| (n_ok && e_ok && opp_board[sq - 6'd7])
		|| (s_ok && w_ok && opp_board[sq + 6'd7])
		|| (s_ok && e_ok && opp_board[sq + 6'd9]);

	assign cand = !own_board[sq] && !opp_board[sq] && nbr_hit;

	always_ff @(posedge clk50) begin
		if (!rst_n) begin
			running <= 1'b0;
			sq <= '0;
			scan_done <= 1'b0;
			result <= '0;
		end else begin
			scan_done <= 1'b0;
			if (scan_start) begin
				running <= 1'b1;
				sq <= '0;
				result <= '0; // Fresh search
			end else if (running) begin
				if (cand) begin
					result.count <= result.count + 7'd1;
					if (!result.found) begin
						result.found <= 1'b1; // First hit is the lowest index
						result.square <= sq;
					end
				end
				sq <= sq + 6'd1;
				if (sq == 6'd63) begin
					running <= 1'b0;
					scan_done <= 1'b1; // 64 cycles after scan_start
				end
			end
		end
	end

endmodule

// File: logic/othello_board_top.sv
`timescale 1ns/1ps

module othello_board_top (
	input logic clk50,
	input logic rst_n,
	input logic uart_rxd,
	output logic uart_txd,
	output logic [6:0] hex0,
	output logic [6:0] hex1,
	output logic [6:0] hex2,
	output logic [6:0] hex3,
	output logic [6:0] hex4,
	output logic [6:0] hex5,
	output logic [6:0] hex6,
	output logic [6:0] hex7
);
	import othello_pkg::*;

	logic [7:0] rx_data;
	logic rx_ready;
	logic [7:0] tx_data;
	logic tx_start;
	logic tx_busy;
	board_t own_board;
	board_t opp_board;
	logic scan_start;
	logic scan_done;
	move_result_t result;
	display_t display;

	uart_rx u_rx (.clk50(clk50), .rst_n(rst_n), .rxd(uart_rxd),
		.rx_data(rx_data), .rx_ready(rx_ready));

	// Host protocol, owns both boards and the display snapshot
	cmd_decode u_dec (.clk50(clk50), .rst_n(rst_n),
		.rx_data(rx_data), .rx_ready(rx_ready),
		.tx_data(tx_data), .tx_start(tx_start), .tx_busy(tx_busy),
		.own_board(own_board), .opp_board(opp_board),
		.scan_start(scan_start), .scan_done(scan_done), .result(result),
		.display(display));

	move_scan u_scan (.clk50(clk50), .rst_n(rst_n),
		.own_board(own_board), .opp_board(opp_board),
		.scan_start(scan_start), .scan_done(scan_done), .result(result));

	uart_tx u_tx (.clk50(clk50), .rst_n(rst_n), .tx_data(tx_data),
		.tx_start(tx_start), .txd(uart_txd), .tx_busy(tx_busy));

	seg7_bank u_seg (.clk50(clk50), .rst_n(rst_n), .display(display),
		.hex0(hex0), .hex1(hex1), .hex2(hex2), .hex3(hex3),
		.hex4(hex4), .hex5(hex5), .hex6(hex6), .hex7(hex7));

endmodule

// File: logic/othello_pkg.sv
package othello_pkg;

	localparam int CLKS_PER_BIT = 16; // Sim rate, far above a real baud
	localparam int CNT_W = $clog2(CLKS_PER_BIT); // Bit-timer width

	// Command opcodes, ASCII 'O', 'X', 'G'
	localparam logic [7:0] OP_OWN = 8'h4F;
	localparam logic [7:0] OP_OPP = 8'h58;
	localparam logic [7:0] OP_GO = 8'h47;

	localparam logic [7:0] REPLY_UNKNOWN = 8'h3F; // '?' for anything else
	localparam logic [7:0] NO_MOVE = 8'hFF; // Square byte when nothing found

	typedef logic [63:0] board_t; // Bit i is square i, row i/8, col i%8

	typedef struct packed {
		logic found; // At least one candidate
		logic [5:0] square; // Lowest candidate index
		logic [6:0] count; // 0..64
	} move_result_t;

	// Packed so hex7 shows own_low[15:12] and hex0 shows count[3:0]
	typedef struct packed {
		logic [15:0] own_low;
		logic [7:0] square;
		logic [7:0] count;
	} display_t;

	// Active low, bit 0 is segment a, bit 6 is segment g
	function automatic logic [6:0] hex_to_seg(input logic [3:0] nib);
		logic [6:0] seg;
		case (nib)
			4'h0: seg = 7'b1000000;
			4'h1: seg = 7'b1111001;
			4'h2: seg = 7'b0100100;
			4'h3: seg = 7'b0110000;
			4'h4: seg = 7'b0011001;
			4'h5: seg = 7'b0010010;
			4'h6: seg = 7'b0000010;
			4'h7: seg = 7'b1111000;
			4'h8: seg = 7'b0000000;
			4'h9: seg = 7'b0011000;
			4'ha: seg = 7'b0001000;
			4'hb: seg = 7'b0000011;
			4'hc: seg = 7'b1000110;
			4'hd: seg = 7'b0100001;
			4'he: seg = 7'b0000110;
			default: seg = 7'b0001110; // f
		endcase
		return seg;
	endfunction

endpackage

// File: logic/seg7_bank.sv
`timescale 1ns/1ps

module seg7_bank (
	input logic clk50,
	input logic rst_n,
	input othello_pkg::display_t display,
	output logic [6:0] hex0,
	output logic [6:0] hex1,
	output logic [6:0] hex2,
	output logic [6:0] hex3,
	output logic [6:0] hex4,
	output logic [6:0] hex5,
	output logic [6:0] hex6,
	output logic [6:0] hex7
);
	import othello_pkg::*;

	logic [6:0] seg_q [8]; // Digit i shows nibble i

	always_ff @(posedge clk50) begin
		for (int i = 0; i < 8; i++) begin
			if (!rst_n)
				seg_q[i] <= hex_to_seg(4'h0); // Blank board shows all zeros
			else
				seg_q[i] <= hex_to_seg(display[4*i +: 4]);
		end
	end

	assign hex0 = seg_q[0]; // Count low nibble
	assign hex1 = seg_q[1];
	assign hex2 = seg_q[2]; // Square byte
	assign hex3 = seg_q[3];
	assign hex4 = seg_q[4]; // Own board [15:0]
	assign hex5 = seg_q[5];
	assign hex6 = seg_q[6];
	assign hex7 = seg_q[7];

endmodule

// File: logic/uart_rx.sv
`timescale 1ns/1ps

module uart_rx (
	input logic clk50,
	input logic rst_n,
	input logic rxd,
	output logic [7:0] rx_data,
	output logic rx_ready
);
	import othello_pkg::*;

	typedef enum logic [1:0] {R_IDLE, R_START, R_DATA, R_STOP} rx_state_t;

	rx_state_t state;
	logic rxd_meta; // Two-flop sync on the async line
	logic rxd_s;
	logic [CNT_W-1:0] clk_cnt; // Cycles within the current bit
	logic [2:0] bit_idx;
	logic [7:0] shreg; // Data bits, LSB arrives first

	always_ff @(posedge clk50) begin
		if (!rst_n) begin
			rxd_meta <= 1'b1; // Line idles high
			rxd_s <= 1'b1;
			state <= R_IDLE;
			clk_cnt <= '0;
			bit_idx <= '0;
			rx_ready <= 1'b0;
		end else begin
			rxd_meta <= rxd;
			rxd_s <= rxd_meta;
			rx_ready <= 1'b0; // One-cycle pulse
			case (state)
				R_IDLE: begin
					clk_cnt <= '0;
					if (!rxd_s)
						state <= R_START; // Falling edge, maybe a start bit
				end
				R_START: begin
					if (clk_cnt == CNT_W'(CLKS_PER_BIT / 2 - 1)) begin
						clk_cnt <= '0;
						bit_idx <= '0;
						state <= rxd_s ? R_IDLE : R_DATA; // Glitch if high at mid-bit
					end else
						clk_cnt <= clk_cnt + 1'b1;
				end
				R_DATA: begin
					if (clk_cnt == CNT_W'(CLKS_PER_BIT - 1)) begin
						clk_cnt <= '0;
						bit_idx <= bit_idx + 3'd1;
						if (bit_idx == 3'd7)
							state <= R_STOP;
					end else
						clk_cnt <= clk_cnt + 1'b1;
				end
				default: begin // R_STOP
					if (clk_cnt == CNT_W'(CLKS_PER_BIT - 1)) begin
						clk_cnt <= '0;
						rx_ready <= rxd_s; // Framing error drops the byte
						state <= R_IDLE;
					end else
						clk_cnt <= clk_cnt + 1'b1;
				end
			endcase
		end
	end

	// Sample mid-bit, publish only on a good stop bit
	always_ff @(posedge clk50) begin
		if (state == R_DATA && clk_cnt == CNT_W'(CLKS_PER_BIT - 1))
			shreg <= {rxd_s, shreg[7:1]};
		if (state == R_STOP && clk_cnt == CNT_W'(CLKS_PER_BIT - 1) && rxd_s)
			rx_data <= shreg;
	end

endmodule

// File: logic/uart_tx.sv
`timescale 1ns/1ps

module uart_tx (
	input logic clk50,
	input logic rst_n,
	input logic [7:0] tx_data,
	input logic tx_start,
	output logic txd,
	output logic tx_busy
);
	import othello_pkg::*;

	logic [CNT_W-1:0] clk_cnt;
	logic [3:0] bit_idx; // 0 start, 1..8 data, 9 stop
	logic [8:0] shreg; // Data bits then the stop bit

	always_ff @(posedge clk50) begin
		if (!rst_n) begin
			txd <= 1'b1; // Idle high
			tx_busy <= 1'b0;
			clk_cnt <= '0;
			bit_idx <= '0;
		end else if (!tx_busy) begin
			if (tx_start) begin
				txd <= 1'b0; // Start bit goes out right away
				tx_busy <= 1'b1;
				clk_cnt <= '0;
				bit_idx <= '0;
			end
		end else if (clk_cnt == CNT_W'(CLKS_PER_BIT - 1)) begin
			clk_cnt <= '0;
			if (bit_idx == 4'd9)
				tx_busy <= 1'b0; // Stop bit finished, line already high
			else begin
				txd <= shreg[0];
				bit_idx <= bit_idx + 4'd1;
			end
		end else
			clk_cnt <= clk_cnt + 1'b1;
	end

	// Frame payload, shifted once per bit boundary
	always_ff @(posedge clk50) begin
		if (!tx_busy && tx_start)
			shreg <= {1'b1, tx_data};
		else if (tx_busy && clk_cnt == CNT_W'(CLKS_PER_BIT - 1) && bit_idx != 4'd9)
			shreg <= {1'b1, shreg[8:1]};
	end

endmodule

// File: project.f
logic/othello_pkg.sv
logic/uart_rx.sv
logic/uart_tx.sv
logic/cmd_decode.sv
logic/move_scan.sv
logic/seg7_bank.sv
logic/othello_board_top.sv
dv/othello_board_tb.sv
